/* src/eth_bridge_pkg.sv */
/*
 * eth bridge shared types: byte and lane word widths, MAC stream and
 * FIFO entry structs, MAC status union and strap word layout
 */
package eth_bridge_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    // one Ethernet byte
    typedef logic [7:0] byte_t;

    // bytes per serial lane word, also the port count limit
    localparam int LANE_BYTES = 4;

    // lane word, byte lane x belongs to port x
    typedef byte_t [LANE_BYTES-1:0] lane_word_t;

    // strap word width
    localparam int STRAP_W = 10;

    // ----------------------------------------------------------
    // streams
    // ----------------------------------------------------------
    // buffered byte with its end-of-frame mark
    typedef struct packed {
        byte_t data;
        logic  last;
    } fifo_entry_t;

    // byte-wide MAC stream, sof/eof qualified by valid
    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sof;
        logic  eof;
    } mac_stream_t;

    // ----------------------------------------------------------
    // MAC status and straps
    // ----------------------------------------------------------
    // speed code for 1000 Mb/s
    localparam logic [1:0] SPEED_GIGABIT = 2'b10;

    // MAC status word, raw or split into link and speed
    typedef union packed {
        logic [3:0] raw;
        struct packed {
            logic       reserved;
            logic [1:0] speed;
            logic       link;
        } fields;
    } port_status_u;

    // strap word layout, unnamed bits are spare
    typedef struct packed {
        logic       spare_hi;
        logic       power_down;
        logic [2:0] loopback;
        logic [2:0] spare_mid;
        logic       lane_rst;
        logic       gt_rst;
    } lane_ctrl_t;

endpackage

/* src/byte_fifo.sv */
/*
 * byte fifo: circular buffer of byte-plus-last entries,
 * head entry falls through to the output while not empty
 */
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        clk20_g,
    input  logic                        arst_n_i,
    input  logic                        wr_i,
    input  eth_bridge_pkg::fifo_entry_t wr_entry_i,
    input  logic                        rd_i,
    output eth_bridge_pkg::fifo_entry_t rd_entry_o,
    output logic                        empty_o,
    output logic                        full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    eth_bridge_pkg::fifo_entry_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        do_wr;
    logic                        do_rd;

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // write while full is dropped, read while empty ignored
    assign do_wr = wr_i & ~full_o;
    assign do_rd = rd_i & ~empty_o;

    // storage
    always_ff @(posedge clk20_g) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head visible the cycle after its write
    assign rd_entry_o = mem[rd_ptr];
    assign empty_o    = (count == '0);
    assign full_o     = (count == CNT_W'(FIFO_DEPTH));

endmodule

/* src/port_tx_path.sv */
/*
 * port tx path: buffers one byte lane of the serial stream and
 * replays it to the MAC with start- and end-of-frame marks
 */
`timescale 1ns/1ps

module port_tx_path #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        clk20_g,
    input  logic                        arst_n_i,
    input  eth_bridge_pkg::byte_t       lane_byte_i,
    input  logic                        lane_valid_i,
    input  logic                        lane_last_i,
    output eth_bridge_pkg::mac_stream_t mac_tx_o
);

    eth_bridge_pkg::fifo_entry_t wr_entry;
    eth_bridge_pkg::fifo_entry_t head;
    logic                        empty;
    logic                        pop;
    logic                        frame_open;

    assign wr_entry.data = lane_byte_i;
    assign wr_entry.last = lane_last_i;

    // MAC always ready, drain one entry per cycle
    assign pop = ~empty;

    // no back-pressure toward the lane
    // overrun bytes are lost inside the fifo
    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tx_fifo_i (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .wr_i       (lane_valid_i),
        .wr_entry_i (wr_entry),
        .rd_i       (pop),
        .rd_entry_o (head),
        .empty_o    (empty),
        .full_o     ()
    );

    // ----------------------------------------------------------
    // frame tracking
    // ----------------------------------------------------------
    // open after a non-last byte, closed again by the eof byte
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            frame_open <= 1'b0;
        end else if (pop) begin
            frame_open <= ~head.last;
        end
    end

    // sof on the first byte of each frame
    assign mac_tx_o.data  = head.data;
    assign mac_tx_o.valid = pop;
    assign mac_tx_o.sof   = pop & ~frame_open;
    assign mac_tx_o.eof   = pop & head.last;

endmodule

/* src/port_rx_path.sv */
/*
 * port rx path: buffers MAC receive bytes while the link is up at
 * gigabit speed and offers them to one byte lane of the serial stream
 */
`timescale 1ns/1ps

module port_rx_path #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         clk20_g,
    input  logic                         arst_n_i,
    input  eth_bridge_pkg::mac_stream_t  mac_rx_i,
    input  eth_bridge_pkg::port_status_u status_i,
    input  logic                         lane_ready_i,
    output eth_bridge_pkg::byte_t        lane_byte_o,
    output logic                         lane_valid_o,
    output logic                         lane_last_o,
    output logic                         overflow_o
);

    eth_bridge_pkg::fifo_entry_t wr_entry;
    eth_bridge_pkg::fifo_entry_t head;
    logic                        link_ok;
    logic                        wr;
    logic                        pop;
    logic                        empty;
    logic                        full;

    // ----------------------------------------------------------
    // link qualification
    // ----------------------------------------------------------
    // only link up at 1000 Mb/s passes bytes
    assign link_ok = status_i.fields.link &&
                     (status_i.fields.speed == eth_bridge_pkg::SPEED_GIGABIT);

    // bytes outside a qualified link are dropped
    assign wr = mac_rx_i.valid & link_ok;

    // eof closes the frame, sof not stored
    assign wr_entry.data = mac_rx_i.data;
    assign wr_entry.last = mac_rx_i.eof;

    // pop on the lane handshake
    assign pop = ~empty & lane_ready_i;

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_fifo_i (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .wr_i       (wr),
        .wr_entry_i (wr_entry),
        .rd_i       (pop),
        .rd_entry_o (head),
        .empty_o    (empty),
        .full_o     (full)
    );

    // ----------------------------------------------------------
    // overflow
    // ----------------------------------------------------------
    // sticky until reset, set by a write that found the fifo full
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            overflow_o <= 1'b0;
        end else if (wr && full) begin
            overflow_o <= 1'b1;
        end
    end

    // lane side straight from the fifo head
    // holds while ready is low
    assign lane_byte_o  = head.data;
    assign lane_valid_o = ~empty;
    assign lane_last_o  = ~empty & head.last;

endmodule

/* src/heartbeat_timer.sv */
/*
 * heartbeat timer: microsecond and millisecond tick chain,
 * blink output toggles every BLINK_HALF_MS milliseconds
 */
`timescale 1ns/1ps

module heartbeat_timer #(
    parameter int CLK_PER_US    = 20,
    parameter int US_PER_MS     = 1000,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic clk20_g,
    input  logic arst_n_i,
    output logic blink_o
);

    localparam int US_W   = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
    localparam int MS_W   = (US_PER_MS > 1) ? $clog2(US_PER_MS) : 1;
    localparam int HALF_W = (BLINK_HALF_MS > 1) ? $clog2(BLINK_HALF_MS) : 1;

    logic [US_W-1:0]   us_cnt;
    logic [MS_W-1:0]   ms_cnt;
    logic [HALF_W-1:0] half_cnt;
    logic              us_tick;
    logic              ms_tick;
    logic              half_tick;

    // each tick is the last count of its stage
    assign us_tick   = (us_cnt == US_W'(CLK_PER_US - 1));
    assign ms_tick   = us_tick && (ms_cnt == MS_W'(US_PER_MS - 1));
    assign half_tick = ms_tick && (half_cnt == HALF_W'(BLINK_HALF_MS - 1));

    // ----------------------------------------------------------
    // tick chain
    // ----------------------------------------------------------
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            us_cnt   <= '0;
            ms_cnt   <= '0;
            half_cnt <= '0;
        end else begin
            // clocks per microsecond
            us_cnt <= us_tick ? '0 : us_cnt + 1'b1;
            // microseconds per millisecond
            if (us_tick) begin
                ms_cnt <= ms_tick ? '0 : ms_cnt + 1'b1;
            end
            // milliseconds per half period
            if (ms_tick) begin
                half_cnt <= half_tick ? '0 : half_cnt + 1'b1;
            end
        end
    end

    // led toggle, first edge one half period after reset release
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            blink_o <= 1'b0;
        end else if (half_tick) begin
            blink_o <= ~blink_o;
        end
    end

endmodule

/* src/eth_bridge_top.sv */
/*
 * eth bridge top: four-port bridge between the 32-bit serial lane stream
 * and byte-wide MAC streams, plus strap decode and heartbeat led
 */
`timescale 1ns/1ps

module eth_bridge_top #(
    parameter int ETH_COUNT     = 4,
    parameter int FIFO_DEPTH    = 16,
    parameter int CLK_PER_US    = 20,
    parameter int US_PER_MS     = 1000,
    parameter int BLINK_HALF_MS = 125
) (
    input  logic                                         clk20_g,
    input  logic                                         arst_n_i,

    // lane receive, one byte per port
    input  eth_bridge_pkg::lane_word_t                   lane_rx_data_i,
    input  logic                                         lane_rx_valid_i,
    input  logic                                         lane_rx_last_i,

    // lane transmit, per-port valid and last, shared ready
    output eth_bridge_pkg::lane_word_t                   lane_tx_data_o,
    output logic [ETH_COUNT-1:0]                         lane_tx_valid_o,
    output logic [ETH_COUNT-1:0]                         lane_tx_last_o,
    input  logic                                         lane_tx_ready_i,

    // MAC side
    output eth_bridge_pkg::mac_stream_t [ETH_COUNT-1:0]  mac_tx_o,
    input  eth_bridge_pkg::mac_stream_t [ETH_COUNT-1:0]  mac_rx_i,
    input  eth_bridge_pkg::port_status_u [ETH_COUNT-1:0] mac_status_i,
    output logic [ETH_COUNT-1:0]                         rx_overflow_o,

    // straps and transceiver control
    input  logic [eth_bridge_pkg::STRAP_W-1:0]           strap_i,
    output logic                                         gt_rst_o,
    output logic                                         lane_rst_o,
    output logic [2:0]                                   loopback_o,
    output logic                                         power_down_o,

    output logic                                         dbg_led_o
);

    eth_bridge_pkg::lane_ctrl_t lane_ctrl;
    logic                       blink;

    // ----------------------------------------------------------
    // per-port data path
    // ----------------------------------------------------------
    // port x owns byte lane x, at most LANE_BYTES ports
    for (genvar x = 0; x < ETH_COUNT; x++) begin : g_eth
        // lane to MAC
        port_tx_path #(
            .FIFO_DEPTH   (FIFO_DEPTH)
        ) tx_path_i (
            .clk20_g      (clk20_g),
            .arst_n_i     (arst_n_i),
            .lane_byte_i  (lane_rx_data_i[x]),
            .lane_valid_i (lane_rx_valid_i),
            .lane_last_i  (lane_rx_last_i),
            .mac_tx_o     (mac_tx_o[x])
        );

        // MAC to lane
        port_rx_path #(
            .FIFO_DEPTH   (FIFO_DEPTH)
        ) rx_path_i (
            .clk20_g      (clk20_g),
            .arst_n_i     (arst_n_i),
            .mac_rx_i     (mac_rx_i[x]),
            .status_i     (mac_status_i[x]),
            .lane_ready_i (lane_tx_ready_i),
            .lane_byte_o  (lane_tx_data_o[x]),
            .lane_valid_o (lane_tx_valid_o[x]),
            .lane_last_o  (lane_tx_last_o[x]),
            .overflow_o   (rx_overflow_o[x])
        );
    end

    // byte lanes without a port stay zero
    for (genvar b = ETH_COUNT; b < eth_bridge_pkg::LANE_BYTES; b++) begin : g_idle_lane
        assign lane_tx_data_o[b] = '0;
    end

    // ----------------------------------------------------------
    // strap decode
    // ----------------------------------------------------------
    assign lane_ctrl = eth_bridge_pkg::lane_ctrl_t'(strap_i);

    assign gt_rst_o     = lane_ctrl.gt_rst;
    assign lane_rst_o   = lane_ctrl.lane_rst;
    assign loopback_o   = lane_ctrl.loopback;
    assign power_down_o = lane_ctrl.power_down;

    // ----------------------------------------------------------
    // heartbeat
    // ----------------------------------------------------------
    heartbeat_timer #(
        .CLK_PER_US    (CLK_PER_US),
        .US_PER_MS     (US_PER_MS),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) heartbeat_i (
        .clk20_g       (clk20_g),
        .arst_n_i      (arst_n_i),
        .blink_o       (blink)
    )

    ;

    // led dark while the transceiver is held in reset
    assign dbg_led_o = blink & ~lane_ctrl.gt_rst;

endmodule

/* bench/eth_bridge_assert.sv */
/*
 * eth bridge port checks: frame marks only with valid,
 * receive overflow flags sticky
 */
`timescale 1ns/1ps

module eth_bridge_assert #(
    parameter int ETH_COUNT = 4
) (
    input logic                                        clk20_g,
    input logic                                        arst_n_i,
    input eth_bridge_pkg::mac_stream_t [ETH_COUNT-1:0] mac_tx_o,
    input logic [ETH_COUNT-1:0]                        rx_overflow_o
);

    // failed assertion count
    int unsigned fail_count = 0;

    for (genvar x = 0; x < ETH_COUNT; x++) begin : g_port
        // frame marks qualified by valid
        sof_valid_a: assert property (@(posedge clk20_g) disable iff (!arst_n_i)
            mac_tx_o[x].sof |-> mac_tx_o[x].valid)
            else begin
                $error("port %0d: sof without valid", x);
                fail_count++;
            end

        eof_valid_a: assert property (@(posedge clk20_g) disable iff (!arst_n_i)
            mac_tx_o[x].eof |-> mac_tx_o[x].valid)
            else begin
                $error("port %0d: eof without valid", x);
                fail_count++;
            end

        // cleared only by reset
        overflow_sticky_a: assert property (@(posedge clk20_g) disable iff (!arst_n_i)
            !$fell(rx_overflow_o[x]))
            else begin
                $error("port %0d: overflow flag cleared", x);
                fail_count++;
            end
    end

endmodule

bind eth_bridge_top eth_bridge_assert #(
    .ETH_COUNT (ETH_COUNT)
) assert_i (
    .clk20_g         (clk20_g),
    .arst_n_i        (arst_n_i),
    .mac_tx_o        (mac_tx_o),
    .rx_overflow_o   (rx_overflow_o)
);

/* bench/eth_bridge_tb.sv */
/*
 * eth bridge testbench: directed tests of the lane and MAC data paths,
 * receive overflow, strap decode and the heartbeat led
 */
`timescale 1ns/1ps

module eth_bridge_tb;

    localparam int ETH_COUNT     = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int CLK_PER_US    = 20;
    localparam int US_PER_MS     = 4;
    localparam int BLINK_HALF_MS = 2;
    localparam int HALF_CYC      = CLK_PER_US * US_PER_MS * BLINK_HALF_MS;
    localparam int FRAME_LEN     = 3;
    localparam int OVF_LEN       = FIFO_DEPTH + 2;
    // reset, lane, two rx frames, overflow, straps, heartbeat, margin
    localparam int TIMEOUT_CYC   = 5 + (FRAME_LEN + 4) + 2 * (FRAME_LEN + 4)
                                 + (2 * OVF_LEN + 10) + 10 + (3 * HALF_CYC + 60) + 200;

    logic                                         clk20_g;
    logic                                         arst_n;
    eth_bridge_pkg::lane_word_t                   lane_rx_data;
    logic                                         lane_rx_valid;
    logic                                         lane_rx_last;
    eth_bridge_pkg::lane_word_t                   lane_tx_data;
    logic [ETH_COUNT-1:0]                         lane_tx_valid;
    logic [ETH_COUNT-1:0]                         lane_tx_last;
    logic                                         lane_tx_ready;
    eth_bridge_pkg::mac_stream_t [ETH_COUNT-1:0]  mac_tx;
    eth_bridge_pkg::mac_stream_t [ETH_COUNT-1:0]  mac_rx;
    eth_bridge_pkg::port_status_u [ETH_COUNT-1:0] mac_status;
    logic [ETH_COUNT-1:0]                         rx_overflow;
    logic [eth_bridge_pkg::STRAP_W-1:0]           strap;
    logic                                         gt_rst;
    logic                                         lane_rst;
    logic [2:0]                                   loopback;
    logic                                         power_down;
    logic                                         dbg_led;

    logic [31:0] lfsr_state = 32'h064d_7d09;
    int          err_count  = 0;
    int          check_count = 0;
    int unsigned run_cycles;
    int unsigned wd_cycles;

    eth_bridge_top #(
        .ETH_COUNT     (ETH_COUNT),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .CLK_PER_US    (CLK_PER_US),
        .US_PER_MS     (US_PER_MS),
        .BLINK_HALF_MS (BLINK_HALF_MS)
    ) dut_i (
        .clk20_g         (clk20_g),
        .arst_n_i        (arst_n),
        .lane_rx_data_i  (lane_rx_data),
        .lane_rx_valid_i (lane_rx_valid),
        .lane_rx_last_i  (lane_rx_last),
        .lane_tx_data_o  (lane_tx_data),
        .lane_tx_valid_o (lane_tx_valid),
        .lane_tx_last_o  (lane_tx_last),
        .lane_tx_ready_i (lane_tx_ready),
        .mac_tx_o        (mac_tx),
        .mac_rx_i        (mac_rx),
        .mac_status_i    (mac_status),
        .rx_overflow_o   (rx_overflow),
        .strap_i         (strap),
        .gt_rst_o        (gt_rst),
        .lane_rst_o      (lane_rst),
        .loopback_o      (loopback),
        .power_down_o    (power_down),
        .dbg_led_o       (dbg_led)
    );

    // ----------------------------------------------------------
    // clock, cycle count and watchdog
    // ----------------------------------------------------------
    initial begin
        clk20_g = 1'b0;
        forever #10 clk20_g = ~clk20_g;
    end

    // clock edges since reset release, heartbeat reference
    always @(posedge clk20_g or negedge arst_n) begin
        if (!arst_n) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    initial begin
        wd_cycles = 0;
        while (wd_cycles < TIMEOUT_CYC) begin
            @(posedge clk20_g);
            wd_cycles++;
        end
        $display("timeout after %0d cycles, tests did not finish", wd_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %s, %0d errors", name,
                 (err_count == errs_before) ? "ok" : "mismatch", err_count - errs_before);
    endtask

    task automatic drive_rx(input int x, input logic [7:0] data, input logic valid,
                            input logic sof, input logic eof);
        mac_rx[x].data  = data;
        mac_rx[x].valid = valid;
        mac_rx[x].sof   = sof;
        mac_rx[x].eof   = eof;
    endtask

    task automatic set_status(input int x, input logic link, input logic [1:0] speed);
        mac_status[x].fields.reserved = 1'b0;
        mac_status[x].fields.speed    = speed;
        mac_status[x].fields.link     = link;
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    // each port replays its byte lane, sof first, eof last
    task automatic lane_to_mac_test();
        eth_bridge_pkg::lane_word_t words [FRAME_LEN];
        int                         errs;
        errs = err_count;
        for (int i = 0; i < FRAME_LEN; i++) begin
            words[i] = rand_bits(32);
        end
        @(negedge clk20_g);
        lane_rx_data  = words[0];
        lane_rx_valid = 1'b1;
        lane_rx_last  = 1'b0;
        for (int i = 0; i < FRAME_LEN; i++) begin
            @(negedge clk20_g);
            for (int x = 0; x < ETH_COUNT; x++) begin
                check_value($sformatf("mac_tx_o[%0d].valid", x), mac_tx[x].valid, 1);
                check_value($sformatf("mac_tx_o[%0d].data", x), mac_tx[x].data, words[i][x]);
                check_value($sformatf("mac_tx_o[%0d].sof", x), mac_tx[x].sof, i == 0);
                check_value($sformatf("mac_tx_o[%0d].eof", x), mac_tx[x].eof,
                            i == FRAME_LEN - 1);
            end
            if (i < FRAME_LEN - 1) begin
                lane_rx_data = words[i+1];
                lane_rx_last = (i + 1 == FRAME_LEN - 1);
            end else begin
                lane_rx_valid = 1'b0;
                lane_rx_last  = 1'b0;
            end
        end
        @(negedge clk20_g);
        for (int x = 0; x < ETH_COUNT; x++) begin
            check_value($sformatf("mac_tx_o[%0d].valid", x), mac_tx[x].valid, 0);
        end
        report_test("lane to mac", errs);
    endtask

    // one frame per port, only qualified ports reach the lane
    task automatic send_rx_frame(input logic [ETH_COUNT-1:0] qual_mask);
        logic [7:0] frame [ETH_COUNT][FRAME_LEN];
        for (int x = 0; x < ETH_COUNT; x++) begin
            for (int i = 0; i < FRAME_LEN; i++) begin
                frame[x][i] = rand_bits(8);
            end
        end
        @(negedge clk20_g);
        for (int x = 0; x < ETH_COUNT; x++) begin
            drive_rx(x, frame[x][0], 1'b1, 1'b1, 1'b0);
        end
        for (int i = 0; i < FRAME_LEN; i++) begin
            @(negedge clk20_g);
            for (int x = 0; x < ETH_COUNT; x++) begin
                check_value($sformatf("lane_tx_valid_o[%0d]", x), lane_tx_valid[x],
                            qual_mask[x]);
                if (qual_mask[x]) begin
                    check_value($sformatf("lane_tx_data_o[%0d]", x), lane_tx_data[x],
                                frame[x][i]);
                    check_value($sformatf("lane_tx_last_o[%0d]", x), lane_tx_last[x],
                                i == FRAME_LEN - 1);
                end
                if (i < FRAME_LEN - 1) begin
                    drive_rx(x, frame[x][i+1], 1'b1, 1'b0, i + 1 == FRAME_LEN - 1);
                end else begin
                    drive_rx(x, 8'h00, 1'b0, 1'b0, 1'b0);
                end
            end
        end
        @(negedge clk20_g);
        check_value("lane_tx_valid_o", lane_tx_valid, 0);
    endtask

    task automatic link_qual_test();
        int errs;
        errs = err_count;
        lane_tx_ready = 1'b1;
        for (int x = 0; x < ETH_COUNT; x++) begin
            set_status(x, 1'b1, eth_bridge_pkg::SPEED_GIGABIT);
        end
        send_rx_frame(4'b1111);
        // port 2 at 100 Mb/s, port 3 link down
        set_status(2, 1'b1, 2'b01);
        set_status(3, 1'b0, eth_bridge_pkg::SPEED_GIGABIT);
        send_rx_frame(4'b0011);
        report_test("link qualification", errs);
    endtask

    // port 1 fills while the lane stalls, extra bytes are lost
    task automatic overflow_test();
        logic [7:0] bytes [OVF_LEN];
        int         errs;
        errs = err_count;
        for (int x = 0; x < ETH_COUNT; x++) begin
            set_status(x, 1'b1, eth_bridge_pkg::SPEED_GIGABIT);
        end
        lane_tx_ready = 1'b0;
        for (int i = 0; i < OVF_LEN; i++) begin
            bytes[i] = rand_bits(8);
        end
        for (int i = 0; i < OVF_LEN; i++) begin
            @(negedge clk20_g);
            // full after FIFO_DEPTH writes, flag set by the next one
            if (i == FIFO_DEPTH) begin
                check_value("rx_overflow_o[1]", rx_overflow[1], 0);
            end
            if (i == FIFO_DEPTH + 1) begin
                check_value("rx_overflow_o[1]", rx_overflow[1], 1);
            end
            drive_rx(1, bytes[i], 1'b1, i == 0, i == OVF_LEN - 1);
        end
        @(negedge clk20_g);
        drive_rx(1, 8'h00, 1'b0, 1'b0, 1'b0);
        // head holds while ready is low
        repeat (3) begin
            check_value("rx_overflow_o", rx_overflow, 4'b0010);
            check_value("lane_tx_valid_o", lane_tx_valid, 4'b0010);
            check_value("lane_tx_data_o[1]", lane_tx_data[1], bytes[0]);
            @(negedge clk20_g);
        end
        lane_tx_ready = 1'b1;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_value("lane_tx_valid_o[1]", lane_tx_valid[1], 1);
            check_value("lane_tx_data_o[1]", lane_tx_data[1], bytes[i]);
            check_value("lane_tx_last_o[1]", lane_tx_last[1], 0);
            @(negedge clk20_g);
        end
        check_value("lane_tx_valid_o[1]", lane_tx_valid[1], 0);
        check_value("rx_overflow_o", rx_overflow, 4'b0010);
        report_test("back-pressure and overflow", errs);
    endtask

    task automatic strap_test();
        logic [31:0] s;
        int          errs;
        errs = err_count;
        repeat (6) begin
            @(negedge clk20_g);
            s = rand_bits(eth_bridge_pkg::STRAP_W);
            strap = s[eth_bridge_pkg::STRAP_W-1:0];
            #1;
            check_value("gt_rst_o", gt_rst, s[0]);
            check_value("lane_rst_o", lane_rst, s[1]);
            check_value("loopback_o", loopback, s[7:5]);
            check_value("power_down_o", power_down, s[8]);
        end
        @(negedge clk20_g);
        strap = '0;
        report_test("strap decode", errs);
    endtask

    // led level follows the half periods elapsed since reset release
    task automatic heartbeat_test();
        int errs;
        errs = err_count;
        @(negedge clk20_g);
        strap = '0;
        repeat (2 * HALF_CYC + 20) begin
            @(negedge clk20_g);
            check_value("dbg_led_o", dbg_led, (run_cycles / HALF_CYC) % 2);
        end
        // masked while the transceiver reset strap is set
        strap = 10'h001;
        repeat (HALF_CYC + 20) begin
            @(negedge clk20_g);
            check_value("dbg_led_o", dbg_led, 0);
        end
        strap = '0;
        report_test("heartbeat", errs);
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        arst_n        = 1'b0;
        lane_rx_data  = '0;
        lane_rx_valid = 1'b0;
        lane_rx_last  = 1'b0;
        lane_tx_ready = 1'b1;
        mac_rx        = '0;
        mac_status    = '0;
        strap         = '0;
        repeat (5) @(negedge clk20_g);
        arst_n = 1'b1;
        lane_to_mac_test();
        link_qual_test();
        overflow_test();
        strap_test();
        heartbeat_test();
        // port checks in the bound checker
        if (dut_i.assert_i.fail_count != 0) begin
            err_count += dut_i.assert_i.fail_count;
            $display("%0d port assertions failed during the run",
                     dut_i.assert_i.fail_count);
        end
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* eth_bridge_top.f */
src/eth_bridge_pkg.sv
src/byte_fifo.sv
src/port_tx_path.sv
src/port_rx_path.sv
src/heartbeat_timer.sv
src/eth_bridge_top.sv
bench/eth_bridge_assert.sv
bench/eth_bridge_tb.sv

/* Bender.yml */
package:
  name: eth_bridge

sources:
  # package first, then leaf modules up to the top level
  - src/eth_bridge_pkg.sv
  - src/byte_fifo.sv
  - src/port_tx_path.sv
  - src/port_rx_path.sv
  - src/heartbeat_timer.sv
  - src/eth_bridge_top.sv

  - target: test
    files:
      - bench/eth_bridge_assert.sv
      - bench/eth_bridge_tb.sv
